// File: compile.f
+incdir+source
source/cin_link_pkg.sv
source/cin_axil_regs.sv
source/cin_lane_aligner.sv
source/cin_biterr_counter.sv
source/cin_link_top.sv
dv/cin_link_clkgen.sv
dv/cin_link_tb.sv

// File: Makefile
TOP := cin_link_tb
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): compile.f $(wildcard source/*.sv source/*.svh dv/*.sv)
	verilator --binary --timing -Wno-fatal -f compile.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f compile.f --top-module cin_link_top

clean:
	rm -rf obj_dir $(LOG)

// File: dv/cin_link_tb.sv
`timescale 1ns/1ps
`include "cin_link_consts.svh"

module cin_link_tb;
    import cin_link_pkg::*;

    localparam int NL = `CIN_NUM_LANES;
    localparam int MAX_NIB = 4096;
    localparam int TIMEOUT = 2000;
    localparam int N_WORDS = 16;
    localparam int N_FLIPS = 5;
    localparam lane_word_t TRAIN = `CIN_TRAIN_VALUE;

    logic                  clk;
    logic                  rst;
    axil_addr_t            awaddr;
    axil_addr_t            araddr;
    axil_data_t            wdata;
    axil_data_t            rdata;
    axil_data_t            rd;
    logic [3:0]            wstrb;
    logic                  awvalid;
    logic                  awready;
    logic                  wvalid;
    logic                  wready;
    logic                  bvalid;
    logic                  bready;
    logic                  arvalid;
    logic                  arready;
    logic                  rvalid;
    logic                  rready;
    axil_resp_t            bresp;
    axil_resp_t            rresp;
    lane_nibble_t [NL-1:0] nibble;
    lane_word_t [NL-1:0]   word;
    logic [NL-1:0]         valid;

    integer     seed;
    int         errors;
    int         checks;
    int         nib_cnt;
    int         slips;
    // every bit driven after reset, per lane, oldest first
    logic       stream_bits [NL][MAX_NIB*4];
    slip_t      exp_slip [NL];
    int         skip [NL];
    logic       mon_on [NL];
    int         vcount [NL];
    int         flip_left [NL];
    lane_word_t last_exp [NL];

    cin_link_clkgen cin_link_clkgen_inst (.clk_o(clk), .rst_o(rst));

    cin_link_top cin_link_top_inst (
        .cin_clk_i(clk), .rst(rst),
        .s_axil_awaddr_i(awaddr), .s_axil_awvalid_i(awvalid), .s_axil_awready_o(awready),
        .s_axil_wdata_i(wdata), .s_axil_wstrb_i(wstrb), .s_axil_wvalid_i(wvalid),
        .s_axil_wready_o(wready), .s_axil_bresp_o(bresp), .s_axil_bvalid_o(bvalid),
        .s_axil_bready_i(bready), .s_axil_araddr_i(araddr), .s_axil_arvalid_i(arvalid),
        .s_axil_arready_o(arready), .s_axil_rdata_o(rdata), .s_axil_rresp_o(rresp),
        .s_axil_rvalid_o(rvalid), .s_axil_rready_i(rready),
        .cin_nibble_i(nibble), .cin_word_o(word), .cin_valid_o(valid)
    );

    // newest whole word in hand once nibble end_nib is in, word k starts at stream bit 32k+s
    function automatic lane_word_t expected_word(input int lane, input int end_nib,
                                                 input slip_t s);
        lane_word_t w;
        int         k;
        int         first;
        k = (4 * end_nib + 3 - 31 - int'(s)) / 32;
        if (k < 0) begin
            k = 0;
        end
        first = 32 * k + int'(s);
        for (int i = 0; i < 32; i++) begin
            w[31-i] = stream_bits[lane][first+i];
        end
        return w;
    endfunction

    function automatic lane_word_t rotl(input lane_word_t v, input int s);
        return (s == 0) ? v : ((v << s) | (v >> (32 - s)));
    endfunction

    function automatic axil_addr_t reg_addr(input int lane, input int off);
        return axil_addr_t'(lane * `CIN_LANE_STRIDE + off);
    endfunction

    task automatic check_word(input string name, input lane_word_t exp, input lane_word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input err_count_t exp, input err_count_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_data(input string name, input axil_data_t exp, input axil_data_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // sel 0 watches bvalid, sel 1 watches rvalid
    task automatic wait_level(input int sel, input logic level, input string what);
        int t;
        t = 0;
        while (((sel == 0) ? bvalid : rvalid) !== level && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (((sel == 0) ? bvalid : rvalid) !== level) begin
            errors++;
            $display("timeout while waiting for %s", what);
        end
    endtask

    task automatic wait_words(input int lane, input int n);
        int start;
        int t;
        start = vcount[lane];
        t = 0;
        while (vcount[lane] - start < n && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (vcount[lane] - start < n) begin
            errors++;
            $display("timeout, lane %0d gave %0d of %0d words", lane, vcount[lane] - start, n);
        end
    endtask

    task automatic write_reg(input axil_addr_t addr, input axil_data_t data);
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        wait_level(0, 1'b1, "write response");
        if (bresp !== AXIL_OKAY) begin
            errors++;
            $display("write to %h did not answer OKAY", addr);
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
        wait_level(0, 1'b0, "write response to clear");
    endtask

    task automatic read_reg(input axil_addr_t addr, output axil_data_t data);
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b1;
        wait_level(1, 1'b1, "read data");
        data = rdata;
        if (rresp !== AXIL_OKAY) begin
            errors++;
            $display("read of %h did not answer OKAY", addr);
        end
        arvalid = 1'b0;
        wait_level(1, 1'b0, "read data to clear");
    endtask

    // compare finished words, then drive the next nibble of every lane
    always @(negedge clk) begin
        lane_nibble_t nib;
        for (int l = 0; l < NL; l++) begin
            if (valid[l]) begin
                vcount[l]++;
                last_exp[l] = expected_word(l, nib_cnt - 1, exp_slip[l]);
                if (mon_on[l] && skip[l] > 0) begin
                    skip[l]--;
                end else if (mon_on[l]) begin
                    check_word($sformatf("lane %0d word", l), last_exp[l], word[l]);
                end
            end
        end
        if (!rst && nib_cnt < MAX_NIB) begin
            for (int l = 0; l < NL; l++) begin
                nib = TRAIN[31 - 4 * (nib_cnt % 8) -: 4];
                // one flipped bit per word, in its fourth nibble
                if (flip_left[l] > 0 && nib_cnt % 8 == 3) begin
                    nib[$unsigned($random(seed)) % 4] ^= 1'b1;
                    flip_left[l]--;
                end
                nibble[l] = nib;
                for (int b = 0; b < 4; b++) begin
                    stream_bits[l][4 * nib_cnt + b] = nib[3-b];
                end
            end
            nib_cnt++;
        end
    end

    initial begin
        seed    = 86;
        errors  = 0;
        checks  = 0;
        nib_cnt = 0;
        awaddr  = '0;
        araddr  = '0;
        wdata   = '0;
        wstrb   = 4'hF;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        arvalid = 1'b0;
        rready  = 1'b0;
        nibble  = '0;
        for (int l = 0; l < NL; l++) begin
            exp_slip[l]  = '0;
            skip[l]      = 0;
            mon_on[l]    = 1'b0;
            vcount[l]    = 0;
            flip_left[l] = 0;
            last_exp[l]  = TRAIN;
        end

        // disabled lanes stay quiet, ctrl reads zero
        for (int i = 0; i < 60; i++) begin
            @(negedge clk);
        end
        for (int l = 0; l < NL; l++) begin
            if (vcount[l] != 0) begin
                errors++;
                $display("lane %0d gave words while disabled", l);
            end
            read_reg(reg_addr(l, `CIN_REG_CTRL), rd);
            check_data("ctrl after reset", 32'h0, rd);
        end

        // enable all lanes, first two words not checked
        for (int l = 0; l < NL; l++) begin
            write_reg(reg_addr(l, `CIN_REG_CTRL), 32'h1);
        end
        for (int l = 0; l < NL; l++) begin
            skip[l]   = 2;
            mon_on[l] = 1'b1;
        end
        for (int l = 0; l < NL; l++) begin
            wait_words(l, 6);
            check_word("aligned", TRAIN, word[l]);
        end

        // bitslip lane 1
        slips = $unsigned($random(seed)) % 32;
        if (slips == 0) begin
            slips = 7;
        end
        mon_on[1] = 1'b0;
        for (int i = 0; i < slips; i++) begin
            write_reg(reg_addr(1, `CIN_REG_SLIP), 32'h0);
        end
        exp_slip[1] = slip_t'(slips);
        skip[1]     = 2;
        mon_on[1]   = 1'b1;
        wait_words(1, 6);
        check_word("bitslip", rotl(TRAIN, slips), word[1]);
        read_reg(reg_addr(1, `CIN_REG_CTRL), rd);
        check_data("ctrl slip", (axil_data_t'(slips) << 8) | 32'h1, rd);
        // every slipped word mismatches
        write_reg(reg_addr(1, `CIN_REG_BITERR), N_WORDS);
        wait_words(1, N_WORDS + 2);
        read_reg(reg_addr(1, `CIN_REG_BITERR), rd);
        check_count("slipped lane errors", err_count_t'(N_WORDS), err_count_t'(rd[15:0]));
        mon_on[1] = 1'b0;
        write_reg(reg_addr(1, `CIN_REG_CTRL), 32'h3);
        exp_slip[1] = '0;
        skip[1]     = 2;
        mon_on[1]   = 1'b1;
        wait_words(1, 4);
        check_word("slip clear", TRAIN, word[1]);

        // capture of the latest word
        for (int l = 0; l < NL; l++) begin
            read_reg(reg_addr(l, `CIN_REG_CAPTURE), rd);
            check_data($sformatf("capture lane %0d", l), last_exp[l], rd);
        end

        // known flips on lane 2 inside one interval
        write_reg(reg_addr(2, `CIN_REG_BITERR), N_WORDS);
        wait_words(2, 3);
        flip_left[2] = N_FLIPS;
        wait_words(2, N_WORDS - 1);
        read_reg(reg_addr(2, `CIN_REG_BITERR), rd);
        check_count("lane 2 errors", err_count_t'(N_FLIPS), err_count_t'(rd[15:0]));

        // write response held, second unmapped write waits
        @(negedge clk);
        awaddr  = 8'h84;
        wdata   = 32'h1;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b0;
        wait_level(0, 1'b1, "held write response");
        awaddr = 8'h88;
        for (int i = 0; i < 5; i++) begin
            @(negedge clk);
            if (bvalid !== 1'b1 || awready !== 1'b0 || wready !== 1'b0) begin
                errors++;
                $display("write accepted or response dropped while bready was low");
            end
        end
        bready = 1'b1;
        wait_level(0, 1'b0, "first write response to clear");
        wait_level(0, 1'b1, "second write response");
        awvalid = 1'b0;
        wvalid  = 1'b0;
        wait_level(0, 1'b0, "second write response to clear");

        // read data held, unmapped read waits and returns zero
        @(negedge clk);
        araddr  = reg_addr(0, `CIN_REG_CTRL);
        arvalid = 1'b1;
        rready  = 1'b0;
        wait_level(1, 1'b1, "held read data");
        araddr = 8'h40;
        check_data("held ctrl read", 32'h1, rdata);
        for (int i = 0; i < 5; i++) begin
            @(negedge clk);
            check_data("held read data", 32'h1, rdata);
            if (rvalid !== 1'b1 || arready !== 1'b0) begin
                errors++;
                $display("read accepted or data dropped while rready was low");
            end
        end
        rready = 1'b1;
        wait_level(1, 1'b0, "first read data to clear");
        wait_level(1, 1'b1, "unmapped read data");
        check_data("unmapped read", 32'h0, rdata);
        arvalid = 1'b0;
        wait_level(1, 1'b0, "unmapped read data to clear");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: dv/cin_link_clkgen.sv
`timescale 1ns/1ps

module cin_link_clkgen (
    output logic clk_o,
    output logic rst_o
);
    // 20 ns period
    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;
    end

    // reset held through the first four rising edges
    initial begin
        rst_o = 1'b1;
        repeat (4) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

// File: source/cin_link_top.sv
`timescale 1ns/1ps
`include "cin_link_consts.svh"

module cin_link_top (
    input  logic                                         cin_clk_i,
    input  logic                                         rst,
    // axi4-lite slave
    input  cin_link_pkg::axil_addr_t                     s_axil_awaddr_i,
    input  logic                                         s_axil_awvalid_i,
    output logic                                         s_axil_awready_o,
    input  cin_link_pkg::axil_data_t                     s_axil_wdata_i,
    input  logic [$bits(cin_link_pkg::axil_data_t)/8-1:0] s_axil_wstrb_i,
    input  logic                                         s_axil_wvalid_i,
    output logic                                         s_axil_wready_o,
    output cin_link_pkg::axil_resp_t                     s_axil_bresp_o,
    output logic                                         s_axil_bvalid_o,
    input  logic                                         s_axil_bready_i,
    input  cin_link_pkg::axil_addr_t                     s_axil_araddr_i,
    input  logic                                         s_axil_arvalid_i,
    output logic                                         s_axil_arready_o,
    output cin_link_pkg::axil_data_t                     s_axil_rdata_o,
    output cin_link_pkg::axil_resp_t                     s_axil_rresp_o,
    output logic                                         s_axil_rvalid_o,
    input  logic                                         s_axil_rready_i,
    // receive lanes, lane 0 in the low slice
    input  cin_link_pkg::lane_nibble_t [`CIN_NUM_LANES-1:0] cin_nibble_i,
    output cin_link_pkg::lane_word_t [`CIN_NUM_LANES-1:0]   cin_word_o,
    output logic [`CIN_NUM_LANES-1:0]                      cin_valid_o
);
    import cin_link_pkg::*;

    logic [`CIN_NUM_LANES-1:0]           lane_en;
    logic [`CIN_NUM_LANES-1:0]           slip_pulse;
    logic [`CIN_NUM_LANES-1:0]           slip_clr;
    logic [`CIN_NUM_LANES-1:0]           interval_load;
    interval_t                           interval;
    err_count_t [`CIN_NUM_LANES-1:0]     err_count;

    // register block, also captures the lane words it reports
    cin_axil_regs cin_axil_regs_inst (
        .cin_clk_i        (cin_clk_i),
        .rst              (rst),
        .s_axil_awaddr_i  (s_axil_awaddr_i),
        .s_axil_awvalid_i (s_axil_awvalid_i),
        .s_axil_awready_o (s_axil_awready_o),
        .s_axil_wdata_i   (s_axil_wdata_i),
        .s_axil_wstrb_i   (s_axil_wstrb_i),
        .s_axil_wvalid_i  (s_axil_wvalid_i),
        .s_axil_wready_o  (s_axil_wready_o),
        .s_axil_bresp_o   (s_axil_bresp_o),
        .s_axil_bvalid_o  (s_axil_bvalid_o),
        .s_axil_bready_i  (s_axil_bready_i),
        .s_axil_araddr_i  (s_axil_araddr_i),
        .s_axil_arvalid_i (s_axil_arvalid_i),
        .s_axil_arready_o (s_axil_arready_o),
        .s_axil_rdata_o   (s_axil_rdata_o),
        .s_axil_rresp_o   (s_axil_rresp_o),
        .s_axil_rvalid_o  (s_axil_rvalid_o),
        .s_axil_rready_i  (s_axil_rready_i),
        .lane_word_i      (cin_word_o),
        .lane_valid_i     (cin_valid_o),
        .err_count_i      (err_count),
        .lane_en_o        (lane_en),
        .slip_pulse_o     (slip_pulse),
        .slip_clr_o       (slip_clr),
        .interval_load_o  (interval_load),
        .interval_o       (interval)
    );

    // one aligner and one error counter per lane
    for (genvar i = 0; i < `CIN_NUM_LANES; i++) begin : gen_lane
        cin_lane_aligner cin_lane_aligner_inst (
            .cin_clk_i  (cin_clk_i),
            .rst        (rst),
            .nibble_i   (cin_nibble_i[i]),
            .en_i       (lane_en[i]),
            .slip_i     (slip_pulse[i]),
            .slip_clr_i (slip_clr[i]),
            .word_o     (cin_word_o[i]),
            .valid_o    (cin_valid_o[i])
        );

        cin_biterr_counter cin_biterr_counter_inst (
            .cin_clk_i       (cin_clk_i),
            .rst             (rst),
            .word_i          (cin_word_o[i]),
            .valid_i         (cin_valid_o[i]),
            .interval_load_i (interval_load[i]),
            .interval_i      (interval),
            .err_count_o     (err_count[i])
        );
    end

endmodule

// File: source/cin_biterr_counter.sv
`timescale 1ns/1ps
`include "cin_link_consts.svh"

module cin_biterr_counter (
    input  logic                     cin_clk_i,
    input  logic                     rst,
    input  cin_link_pkg::lane_word_t word_i,
    input  logic                     valid_i,
    input  logic                     interval_load_i,
    input  cin_link_pkg::interval_t  interval_i,
    output cin_link_pkg::err_count_t err_count_o
);
    import cin_link_pkg::*;

    interval_t  interval_q;
    interval_t  remain_q;
    err_count_t run_q;
    err_count_t run_next;
    err_count_t err_q;
    logic       mismatch;

    // a whole word counts once however many bits are wrong
    assign mismatch = (word_i != `CIN_TRAIN_VALUE);
    assign run_next = run_q + err_count_t'(mismatch);

    always_ff @(posedge cin_clk_i) begin
        if (rst) begin
            interval_q <= '0;
            remain_q   <= '0;
            run_q      <= '0;
            err_q      <= '0;
        end else if (interval_load_i) begin
            // new interval restarts the window, last result stays visible
            interval_q <= interval_i;
            remain_q   <= interval_i;
            run_q      <= '0;
        end else if (valid_i && (interval_q != '0)) begin
            if (remain_q == interval_t'(1)) begin
                // end of window, latch and start over
                err_q    <= run_next;
                run_q    <= '0;
                remain_q <= interval_q;
            end else begin
                run_q    <= run_next;
                remain_q <= remain_q - 1'b1;
            end
        end
    end

    // count never exceeds the interval, so no saturation needed
    assign err_count_o = err_q;

endmodule

// File: source/cin_lane_aligner.sv
`timescale 1ns/1ps
`include "cin_link_consts.svh"

module cin_lane_aligner (
    input  logic                       cin_clk_i,
    input  logic                       rst,
    input  cin_link_pkg::lane_nibble_t nibble_i,
    input  logic                       en_i,
    input  logic                       slip_i,
    input  logic                       slip_clr_i,
    output cin_link_pkg::lane_word_t   word_o,
    output logic                       valid_o
);
    import cin_link_pkg::*;

    localparam int HIST_W  = 2 * `CIN_WORD_W;
    // nibbles per word and the bits needed to count them
    localparam int PHASE_W = $clog2(`CIN_WORD_W / `CIN_NIBBLE_W);
    // bit position inside one nibble
    localparam int OFS_W   = $clog2(`CIN_NIBBLE_W);

    logic [HIST_W-1:0]        hist_q;
    logic [HIST_W-1:0]        stream;
    logic [PHASE_W:0]         nib_cnt_q;
    logic                     warm_q;
    slip_t                    slip_q;
    logic [PHASE_W+OFS_W:0]   last_bit;
    logic [PHASE_W:0]         last_nib;
    logic [OFS_W-1:0]         ofs;
    logic                     word_done;
    lane_word_t               word_q;
    logic                     valid_q;

    // history plus the nibble arriving now, newest bit at bit 0
    assign stream = {hist_q[HIST_W-`CIN_NIBBLE_W-1:0], nibble_i};

    // stream index of the first word's last bit, s + 31
    assign last_bit = ($bits(last_bit))'(slip_q) + ($bits(last_bit))'(`CIN_WORD_W - 1);
    // nibble that carries it, 7 to 15
    assign last_nib = last_bit[PHASE_W+OFS_W:OFS_W];
    // msb of a nibble is first in time, so position p sits at index 3 - p
    assign ofs      = ~last_bit[OFS_W-1:0];

    // a word ends every eighth nibble at the slipped phase,
    // but not before enough bits have come in for word 0
    assign word_done = (nib_cnt_q[PHASE_W-1:0] == last_nib[PHASE_W-1:0]) &&
                       (warm_q || (nib_cnt_q >= last_nib));

    // bit history and completed word
    always_ff @(posedge cin_clk_i) begin
        hist_q <= stream;
        // hold the finished word apart so the history keeps shifting
        if (word_done) begin
            word_q <= stream[ofs +: `CIN_WORD_W];
        end
    end

    always_ff @(posedge cin_clk_i) begin
        if (rst) begin
            nib_cnt_q <= '0;
            warm_q    <= 1'b0;
            slip_q    <= '0;
            valid_q   <= 1'b0;
        end else begin
            nib_cnt_q <= nib_cnt_q + 1'b1;
            // past nibble 15 every phase match is a full word
            if (&nib_cnt_q) begin
                warm_q <= 1'b1;
            end
            if (slip_clr_i) begin
                slip_q <= '0;
            end else if (slip_i) begin
                slip_q <= slip_q + 1'b1;
            end
            // disabled lanes still assemble, they just stay quiet
            valid_q <= word_done && en_i;
        end
    end

    assign word_o  = word_q;
    assign valid_o = valid_q;

endmodule

// File: source/cin_axil_regs.sv
`timescale 1ns/1ps
`include "cin_link_consts.svh"

module cin_axil_regs (
    input  logic                                         cin_clk_i,
    input  logic                                         rst,
    // write address and data
    input  cin_link_pkg::axil_addr_t                     s_axil_awaddr_i,
    input  logic                                         s_axil_awvalid_i,
    output logic                                         s_axil_awready_o,
    input  cin_link_pkg::axil_data_t                     s_axil_wdata_i,
    input  logic [$bits(cin_link_pkg::axil_data_t)/8-1:0] s_axil_wstrb_i,
    input  logic                                         s_axil_wvalid_i,
    output logic                                         s_axil_wready_o,
    // write response
    output cin_link_pkg::axil_resp_t                     s_axil_bresp_o,
    output logic                                         s_axil_bvalid_o,
    input  logic                                         s_axil_bready_i,
    // read address and data
    input  cin_link_pkg::axil_addr_t                     s_axil_araddr_i,
    input  logic                                         s_axil_arvalid_i,
    output logic                                         s_axil_arready_o,
    output cin_link_pkg::axil_data_t                     s_axil_rdata_o,
    output cin_link_pkg::axil_resp_t                     s_axil_rresp_o,
    output logic                                         s_axil_rvalid_o,
    input  logic                                         s_axil_rready_i,
    // lane status
    input  cin_link_pkg::lane_word_t [`CIN_NUM_LANES-1:0] lane_word_i,
    input  logic [`CIN_NUM_LANES-1:0]                    lane_valid_i,
    input  cin_link_pkg::err_count_t [`CIN_NUM_LANES-1:0] err_count_i,
    // lane control
    output logic [`CIN_NUM_LANES-1:0]                    lane_en_o,
    output logic [`CIN_NUM_LANES-1:0]                    slip_pulse_o,
    output logic [`CIN_NUM_LANES-1:0]                    slip_clr_o,
    output logic [`CIN_NUM_LANES-1:0]                    interval_load_o,
    output cin_link_pkg::interval_t                      interval_o
);
    import cin_link_pkg::*;

    // address splits into lane index above and register offset below
    localparam int LANE_LSB = $clog2(`CIN_LANE_STRIDE);
    localparam int LANE_W   = `CIN_AXIL_ADDR_W - LANE_LSB;

    logic                        wr_hs;
    logic                        rd_hs;
    logic                        bvalid_q;
    logic                        rvalid_q;
    axil_data_t                  rdata_q;
    axil_data_t                  rd_data;
    logic [LANE_W-1:0]           wr_lane;
    logic [LANE_W-1:0]           rd_lane;
    logic [LANE_LSB-1:0]         wr_off;
    logic [LANE_LSB-1:0]         rd_off;
    logic [`CIN_NUM_LANES-1:0]   wr_sel;
    logic [`CIN_NUM_LANES-1:0]   en_q;
    slip_t                       slip_cnt_q [`CIN_NUM_LANES];
    lane_word_t                  last_word_q [`CIN_NUM_LANES];

    // write accepted when address and data meet and no response is pending
    assign s_axil_awready_o = s_axil_awvalid_i && s_axil_wvalid_i && !bvalid_q;
    assign s_axil_wready_o  = s_axil_awready_o;
    assign wr_hs            = s_axil_awready_o;
    // one read in flight at a time
    assign s_axil_arready_o = s_axil_arvalid_i && !rvalid_q;
    assign rd_hs            = s_axil_arready_o;

    assign wr_lane = s_axil_awaddr_i[`CIN_AXIL_ADDR_W-1:LANE_LSB];
    assign wr_off  = s_axil_awaddr_i[LANE_LSB-1:0];
    assign rd_lane = s_axil_araddr_i[`CIN_AXIL_ADDR_W-1:LANE_LSB];
    assign rd_off  = s_axil_araddr_i[LANE_LSB-1:0];

    // lane windows past the last lane decode to nothing
    always_comb begin
        for (int l = 0; l < `CIN_NUM_LANES; l++) begin
            wr_sel[l] = wr_hs && (wr_lane == LANE_W'(l));
        end
    end

    // read mux, unmapped offsets and lanes read zero
    always_comb begin
        rd_data = '0;
        for (int l = 0; l < `CIN_NUM_LANES; l++) begin
            if (rd_lane == LANE_W'(l)) begin
                case (rd_off)
                    `CIN_REG_CTRL: begin
                        rd_data[0]                = en_q[l];
                        rd_data[8 +: $bits(slip_t)] = slip_cnt_q[l];
                    end
                    // a word finishing in the accept cycle counts as latest
                    `CIN_REG_CAPTURE: rd_data = lane_valid_i[l] ? lane_word_i[l]
                                                                : last_word_q[l];
                    `CIN_REG_BITERR:  rd_data = axil_data_t'(err_count_i[l]);
                    default:          rd_data = '0;
                endcase
            end
        end
    end

    // handshakes, enables, strobes and the mirrored slip counts
    always_ff @(posedge cin_clk_i) begin
        if (rst) begin
            bvalid_q        <= 1'b0;
            rvalid_q        <= 1'b0;
            en_q            <= '0;
            slip_pulse_o    <= '0;
            slip_clr_o      <= '0;
            interval_load_o <= '0;
            for (int l = 0; l < `CIN_NUM_LANES; l++) begin
                slip_cnt_q[l] <= '0;
            end
        end else begin
            // responses hold until the host takes them
            if (wr_hs) begin
                bvalid_q <= 1'b1;
            end else if (s_axil_bready_i) begin
                bvalid_q <= 1'b0;
            end
            if (rd_hs) begin
                rvalid_q <= 1'b1;
            end else if (s_axil_rready_i) begin
                rvalid_q <= 1'b0;
            end
            for (int l = 0; l < `CIN_NUM_LANES; l++) begin
                // any write to slip moves the boundary by one bit
                slip_pulse_o[l]    <= wr_sel[l] && (wr_off == `CIN_REG_SLIP);
                slip_clr_o[l]      <= wr_sel[l] && (wr_off == `CIN_REG_CTRL) &&
                                      s_axil_wstrb_i[0] && s_axil_wdata_i[1];
                interval_load_o[l] <= wr_sel[l] && (wr_off == `CIN_REG_BITERR) &&
                                      (&s_axil_wstrb_i[1:0]);
                if (wr_sel[l] && (wr_off == `CIN_REG_CTRL) && s_axil_wstrb_i[0]) begin
                    en_q[l] <= s_axil_wdata_i[0];
                end
                // follow the aligner pointer off the same strobes
                if (slip_clr_o[l]) begin
                    slip_cnt_q[l] <= '0;
                end else if (slip_pulse_o[l]) begin
                    slip_cnt_q[l] <= slip_cnt_q[l] + 1'b1;
                end
            end
        end
    end

    // captured words, read data and the shared interval value
    always_ff @(posedge cin_clk_i) begin
        for (int l = 0; l < `CIN_NUM_LANES; l++) begin
            if (lane_valid_i[l]) begin
                last_word_q[l] <= lane_word_i[l];
            end
        end
        if (rd_hs) begin
            rdata_q <= rd_data;
        end
        // only the lane that sees interval_load picks this up
        if (wr_hs && (wr_off == `CIN_REG_BITERR)) begin
            interval_o <= s_axil_wdata_i[$bits(interval_t)-1:0];
        end
    end

    assign lane_en_o       = en_q;
    assign s_axil_bvalid_o = bvalid_q;
    assign s_axil_bresp_o  = AXIL_OKAY;
    assign s_axil_rvalid_o = rvalid_q;
    assign s_axil_rdata_o  = rdata_q;
    assign s_axil_rresp_o  = AXIL_OKAY;

endmodule

// File: source/cin_link_pkg.sv
`include "cin_link_consts.svh"

package cin_link_pkg;

    // one lane's deserialized input, oldest bit in the msb
    typedef logic [`CIN_NIBBLE_W-1:0] lane_nibble_t;

    // one aligned word
    typedef logic [`CIN_WORD_W-1:0] lane_word_t;

    // bit offset of the word boundary, wraps at one word
    typedef logic [$clog2(`CIN_WORD_W)-1:0] slip_t;

    // error counter and its interval length in words
    typedef logic [15:0] err_count_t;
    typedef logic [15:0] interval_t;

    // axi4-lite payloads
    typedef logic [`CIN_AXIL_ADDR_W-1:0] axil_addr_t;
    typedef logic [31:0] axil_data_t;

    // response codes, the slave only ever answers okay
    typedef enum logic [1:0] {
        AXIL_OKAY   = 2'b00,
        AXIL_EXOKAY = 2'b01,
        AXIL_SLVERR = 2'b10,
        AXIL_DECERR = 2'b11
    } axil_resp_t;

endpackage

// File: source/cin_link_consts.svh
`ifndef CIN_LINK_CONSTS_SVH
`define CIN_LINK_CONSTS_SVH

// lane geometry
`define CIN_NUM_LANES   4
// bits delivered by one lane per cin clock
`define CIN_NIBBLE_W    4
// assembled word width
`define CIN_WORD_W      32

// pattern the far end sends while the link trains
`define CIN_TRAIN_VALUE 32'hA55A6996

// register space, one window per lane
`define CIN_AXIL_ADDR_W 8
`define CIN_LANE_STRIDE 8'h10

// offsets inside one lane window
`define CIN_REG_CTRL    4'h0
`define CIN_REG_SLIP    4'h4
`define CIN_REG_CAPTURE 4'h8
`define CIN_REG_BITERR  4'hC

`endif
